// File: Makefile
# Verilator build and run for the matrix-multiply accelerator

VERILATOR  ?= verilator
TOP        := mm_accel_tb
FILELIST   := verilog.f
OBJ_DIR    := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing -Wall
FAIL_MSG   := Test failed
SIM_BIN    := $(OBJ_DIR)/V$(TOP)
SOURCES    := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides, a crash without a verdict also fails
run: $(SIM_BIN)
	@$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "FAIL: failure reported in $(LOG)"; exit 1; \
	fi; \
	if [ $$status -ne 0 ]; then \
		echo "FAIL: simulator exited with status $$status"; exit 1; \
	fi; \
	echo "PASS: no failure reported in $(LOG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/mm_accel_props.sv
/*
 * DMA engine protocol checks
 * valid/payload hold under stalls and single-cycle pulses
 */
`timescale 1ns/10ps

module mm_accel_props (
    input logic                        clk,
    input logic                        rst_n,
    input mm_pkg::mem_rd_req_t         rd_req_i,
    input logic                        rd_ready_i,
    input mm_pkg::mem_wr_t             wr_i,
    input logic                        wr_ready_i,
    input logic                        mm_start_i,
    input logic                        done_i
);

    // stalled read request keeps valid and address
    rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rd_req_i.valid && !rd_ready_i |=> rd_req_i.valid && $stable(rd_req_i.addr))
        else $error("read request dropped or changed while stalled");

    // stalled write beat keeps valid, address and data
    wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wr_i.valid && !wr_ready_i |=> wr_i.valid && $stable(wr_i.addr) && $stable(wr_i.data))
        else $error("write beat dropped or changed while stalled");

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done_i |=> !done_i)
        else $error("done held longer than one cycle");

    start_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        mm_start_i |=> !mm_start_i)
        else $error("engine start held longer than one cycle");

endmodule

// File: bench/mm_accel_tb.sv
/*
 * testbench for the matrix-multiply accelerator
 * memory model with random stalls, reference product and result checks
 */
`timescale 1ns/10ps

module mm_accel_tb;
    import mm_pkg::*;

    localparam int N_JOBS = 20;

    // input tiles indexed [row][col]
    typedef elem_t [SA_WIDTH-1:0][SA_WIDTH-1:0] elem_tile_t;

    typedef struct packed {
        logic [MEM_DW-1:0] data;
        int unsigned       due;
    } rsp_t;

    typedef struct packed {
        logic [MEM_AW-1:0] addr;
        logic [MEM_DW-1:0] data;
    } wr_beat_t;

    logic        clk;
    logic        rst_n;
    job_cfg_t    cfg;
    logic        start;
    logic        done;
    mem_rd_req_t rd_req;
    logic        rd_ready;
    logic        rd_rvalid;
    tile_vec_t   rd_rdata;
    mem_wr_t     wr;
    logic        wr_ready;

    // sparse memory and in-flight traffic
    logic [MEM_DW-1:0] mem_words [logic [MEM_AW-1:0]];
    rsp_t              rsp_q[$];
    wr_beat_t          wr_q[$];
    logic [MEM_AW-1:0] exp_rd_q[$];
    int                rd_total;
    int                wr_total;
    int                done_cnt;

    // expected result of the running job
    acc_tile_t         exp_c;
    logic [MEM_AW-1:0] exp_c_base;

    mm_accel_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_i       (cfg),
        .start_i     (start),
        .done_o      (done),
        .rd_req_o    (rd_req),
        .rd_ready_i  (rd_ready),
        .rd_rvalid_i (rd_rvalid),
        .rd_rdata_i  (rd_rdata),
        .wr_o        (wr),
        .wr_ready_i  (wr_ready)
    );

    bind dma_engine mm_accel_props u_props (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_req_i   (rd_req_o),
        .rd_ready_i (rd_ready_i),
        .wr_i       (wr_o),
        .wr_ready_i (wr_ready_i),
        .mm_start_i (mm_start_o),
        .done_i     (done_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_acc(string name, acc_t got, acc_t exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED t=%0t %s: got %0d expected %0d",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_addr(string name, logic [MEM_AW-1:0] got, logic [MEM_AW-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED t=%0t %s: got 0x%h expected 0x%h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_tile(string name, acc_tile_t got, acc_tile_t exp);
        for (int r = 0; r < SA_WIDTH; r++) begin
            for (int c = 0; c < SA_WIDTH; c++) begin
                check_acc($sformatf("%s[%0d][%0d]", name, r, c), got[r][c], exp[r][c]);
            end
        end
    endtask

    // tile kinds are all -128 (0), a -128/127 checkerboard (1) or random
    function automatic elem_tile_t make_tile(int kind);
        elem_tile_t t;
        for (int r = 0; r < SA_WIDTH; r++) begin
            for (int c = 0; c < SA_WIDTH; c++) begin
                case (kind)
                    0:       t[r][c] = elem_t'(8'h80);
                    1:       t[r][c] = ((r + c) % 2 == 0) ? elem_t'(8'h80) : elem_t'(8'h7f);
                    default: t[r][c] = elem_t'($urandom);
                endcase
            end
        end
        return t;
    endfunction

    // dot-product form C[r][c] = sum over k of A[r][k] * B[k][c]
    function automatic acc_tile_t ref_product(elem_tile_t a, elem_tile_t b);
        acc_tile_t c_t;
        c_t = '0;
        for (int r = 0; r < SA_WIDTH; r++) begin
            for (int c = 0; c < SA_WIDTH; c++) begin
                for (int k = 0; k < SA_WIDTH; k++) begin
                    c_t[r][c] = c_t[r][c] + acc_t'(a[r][k]) * acc_t'(b[k][c]);
                end
            end
        end
        return c_t;
    endfunction

    // memory model decides everything on the falling edge
    // valid seen here is the value the next rising edge samples
    initial begin : mem_model
        rsp_t              rsp;
        logic [MEM_AW-1:0] exp_addr;
        int unsigned       cyc;
        rd_ready  = 1'b0;
        rd_rvalid = 1'b0;
        rd_rdata  = '0;
        wr_ready  = 1'b0;
        cyc       = 0;
        forever begin
            @(negedge clk);
            cyc++;
            // in-order responses once their latency has run out
            if (rsp_q.size() > 0 && rsp_q[0].due <= cyc) begin
                rsp       = rsp_q.pop_front();
                rd_rvalid = 1'b1;
                rd_rdata  = rsp.data;
            end else begin
                rd_rvalid = 1'b0;
                rd_rdata  = '0;
            end
            rd_ready = ($urandom_range(0, 3) != 0);
            if (rd_req.valid && rd_ready) begin
                if (exp_rd_q.size() == 0) begin
                    report_failure("read request issued when no read was expected");
                end
                exp_addr = exp_rd_q.pop_front();
                check_addr("rd_req_o.addr", rd_req.addr, exp_addr);
                // unwritten words return a pattern built from the address
                rsp.data = mem_words.exists(rd_req.addr) ? mem_words[rd_req.addr]
                                                         : ~rd_req.addr ^ 32'h5a5a_a5a5;
                rsp.due  = cyc + $urandom_range(1, 5);
                rsp_q.push_back(rsp);
                rd_total++;
            end
            wr_ready = ($urandom_range(0, 2) != 0);
            if (wr.valid && wr_ready) begin
                mem_words[wr.addr] = wr.data;
                wr_q.push_back('{addr: wr.addr, data: wr.data});
            end
        end
    end

    // compare every accepted write beat with the reference tile
    initial begin : write_check
        wr_beat_t beat;
        int       n;
        forever begin
            @(posedge clk);
            while (wr_q.size() > 0) begin
                beat = wr_q.pop_front();
                n    = wr_total % C_BEATS;
                check_addr("wr_o.addr", beat.addr, exp_c_base + MEM_AW'(n * BEAT_BYTES));
                check_acc("wr_o.data", acc_t'(beat.data), exp_c[n / SA_WIDTH][n % SA_WIDTH]);
                wr_total++;
            end
        end
    end

    // the 16th beat of a job lands on the rising edge just before done is seen
    initial begin : done_monitor
        int prev_total;
        prev_total = 0;
        forever begin
            @(negedge clk);
            if (done === 1'b1) begin
                if (wr_total != C_BEATS * (done_cnt + 1)
                        || prev_total != C_BEATS * (done_cnt + 1) - 1) begin
                    report_failure("done_o did not pulse one cycle after the 16th write beat");
                end
                done_cnt++;
            end
            prev_total = wr_total;
        end
    end

    initial begin : watchdog
        repeat (N_JOBS * 400) @(posedge clk);
        report_failure("timeout, the jobs did not finish within the cycle budget");
    end

    initial begin : stimulus
        elem_tile_t        a_t;
        elem_tile_t        b_t;
        job_cfg_t          job;
        tile_vec_t         beat;
        acc_tile_t         got_c;
        logic [MEM_AW-1:0] addr;
        void'($urandom(13439));
        rst_n = 1'b0;
        cfg   = '0;
        start = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int j = 0; j < N_JOBS; j++) begin
            // first three jobs hit the signed corners
            a_t = make_tile((j < 2) ? 0 : ((j == 2) ? 1 : 2));
            b_t = make_tile((j == 0) ? 0 : ((j < 3) ? 1 : 2));
            job.mat_a_addr = 32'h1000_0000 + MEM_AW'($urandom_range(0, 65535)) * 64;
            job.mat_b_addr = 32'h2000_0000 + MEM_AW'($urandom_range(0, 65535)) * 64;
            job.mat_c_addr = 32'h3000_0000 + MEM_AW'($urandom_range(0, 65535)) * 64;

            // A is column-major so beat k is column k
            for (int k = 0; k < SA_WIDTH; k++) begin
                for (int i = 0; i < SA_WIDTH; i++) begin
                    beat[i] = a_t[i][k];
                end
                addr = job.mat_a_addr + MEM_AW'(k * BEAT_BYTES);
                mem_words[addr] = beat;
                exp_rd_q.push_back(addr);
            end
            // B is row-major so beat k is row k
            for (int k = 0; k < SA_WIDTH; k++) begin
                addr = job.mat_b_addr + MEM_AW'(k * BEAT_BYTES);
                mem_words[addr] = b_t[k];
                exp_rd_q.push_back(addr);
            end
            for (int n = 0; n < C_BEATS; n++) begin
                mem_words.delete(job.mat_c_addr + MEM_AW'(n * BEAT_BYTES));
            end
            exp_c      = ref_product(a_t, b_t);
            exp_c_base = job.mat_c_addr;

            @(negedge clk);
            cfg   = job;
            start = 1'b1;
            @(negedge clk);
            // stray start with junk addresses that the busy job ignores
            cfg   = ~job;
            start = (j % 2 == 1);
            @(negedge clk);
            start = 1'b0;

            do begin
                @(negedge clk);
            end while (done !== 1'b1);
            repeat (2) @(negedge clk);
            if (done_cnt != j + 1) begin
                report_failure("done_o did not pulse exactly once for the job");
            end
            if (rd_total != READ_BEATS * (j + 1) || exp_rd_q.size() != 0) begin
                report_failure("the job did not issue exactly 8 read requests");
            end
            if (wr_total != C_BEATS * (j + 1)) begin
                report_failure("the job did not write exactly 16 beats");
            end

            // C as it landed in memory
            for (int n = 0; n < C_BEATS; n++) begin
                addr = exp_c_base + MEM_AW'(n * BEAT_BYTES);
                if (!mem_words.exists(addr)) begin
                    report_failure("a word of C was never written to memory");
                end
                got_c[n / SA_WIDTH][n % SA_WIDTH] = acc_t'(mem_words[addr]);
            end
            check_tile("mem C", got_c, exp_c);
        end

        // idle stretch after the last job where a stray beat or pulse would raise a total
        repeat (32) @(negedge clk);
        if (done_cnt == N_JOBS && wr_total == C_BEATS * N_JOBS
                && rd_total == READ_BEATS * N_JOBS) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            report_failure("job or beat totals changed after the last job");
        end
    end

endmodule

// File: design/dma_engine.sv
/*
 * DMA job sequencer
 * fetches A and B into the tile buffers, pulses the engine,
 * then writes the 16 results of C back to memory row-major
 */
`timescale 1ns/10ps

module dma_engine (
    input  logic                  clk,
    input  logic                  rst_n,

    // job control
    input  mm_pkg::job_cfg_t      cfg_i,
    input  logic                  start_i,
    output logic                  done_o,

    // memory read channel
    output mm_pkg::mem_rd_req_t   rd_req_o,
    input  logic                  rd_ready_i,
    input  logic                  rd_rvalid_i,
    input  mm_pkg::tile_vec_t     rd_rdata_i,

    // tile buffer writes
    output mm_pkg::buf_wr_t       buf_a_wr_o,
    output mm_pkg::buf_wr_t       buf_b_wr_o,

    // engine handshake
    output logic                  mm_start_o,
    input  logic                  mm_done_i,
    input  mm_pkg::acc_tile_t     accum_i,

    // memory write channel
    output mm_pkg::mem_wr_t       wr_o,
    input  logic                  wr_ready_i
);
    import mm_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_FETCH,
        S_WAIT,
        S_WRITE
    } state_t;

    state_t state_q;
    state_t state_d;

    // latched job addresses
    job_cfg_t cfg_q;

    // fetch side, issued and returned counts run apart
    logic [FETCH_CW-1:0] req_cnt_q;
    logic [FETCH_CW-1:0] rsp_cnt_q;
    logic                rd_fire;
    logic                rsp_take;
    logic                rsp_last;
    logic [MEM_AW-1:0]   rd_base;

    // write back element index, row in upper bits
    logic [C_IDX_W-1:0]  wr_idx_q;
    logic                wr_fire;
    logic                wr_last;

    // registered buffer write, shared address and data
    logic                buf_a_wren_q;
    logic                buf_b_wren_q;
    logic [BUF_AW-1:0]   buf_waddr_q;
    tile_vec_t           buf_wdata_q;

    // read requests
    // first SA_WIDTH beats from A, the rest from B
    assign rd_base  = (req_cnt_q < FETCH_CW'(SA_WIDTH)) ? cfg_q.mat_a_addr : cfg_q.mat_b_addr;
    assign rd_req_o = '{
        valid: (state_q == S_FETCH) && (req_cnt_q < FETCH_CW'(READ_BEATS)),
        addr:  rd_base + MEM_AW'(req_cnt_q[BUF_AW-1:0]) * BEAT_BYTES
    };
    assign rd_fire  = rd_req_o.valid && rd_ready_i;

    // responses come back in order and cannot be stalled
    assign rsp_take = (state_q == S_FETCH) && rd_rvalid_i;
    assign rsp_last = rsp_take && (rsp_cnt_q == FETCH_CW'(READ_BEATS - 1));

    // write beats, payload is combinational off held registers
    assign wr_o = '{
        valid: (state_q == S_WRITE),
        addr:  cfg_q.mat_c_addr + MEM_AW'(wr_idx_q) * BEAT_BYTES,
        data:  accum_i[wr_idx_q[C_IDX_W-1:BUF_AW]][wr_idx_q[BUF_AW-1:0]]
    };
    assign wr_fire = wr_o.valid && wr_ready_i;
    assign wr_last = wr_fire && (wr_idx_q == C_IDX_W'(C_BEATS - 1));

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (start_i) begin
                    state_d = S_FETCH;
                end
            end
            // leave once the 8th response lands
            S_FETCH: begin
                if (rsp_last) begin
                    state_d = S_WAIT;
                end
            end
            S_WAIT: begin
                if (mm_done_i) begin
                    state_d = S_WRITE;
                end
            end
            S_WRITE: begin
                if (wr_last) begin
                    state_d = S_IDLE;
                end
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase
    end

    // control registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= S_IDLE;
            req_cnt_q  <= '0;
            rsp_cnt_q  <= '0;
            wr_idx_q   <= '0;
            mm_start_o <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            state_q    <= state_d;
            // single-cycle pulse the cycle after the last response
            mm_start_o <= rsp_last;
            // single-cycle pulse after the 16th accepted beat
            done_o     <= wr_last;

            if (state_q == S_IDLE && start_i) begin
                req_cnt_q <= '0;
                rsp_cnt_q <= '0;
            end else begin
                if (rd_fire) begin
                    req_cnt_q <= req_cnt_q + 1'b1;
                end
                if (rsp_take) begin
                    rsp_cnt_q <= rsp_cnt_q + 1'b1;
                end
            end

            // index only moves on an accepted beat
            if (state_q == S_WAIT) begin
                wr_idx_q <= '0;
            end else if (wr_fire) begin
                wr_idx_q <= wr_idx_q + 1'b1;
            end
        end
    end

    // job addresses, sampled with start in idle
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && start_i) begin
            cfg_q <= cfg_i;
        end
    end

    // buffer write enables
    // response count picks the target buffer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_a_wren_q <= 1'b0;
            buf_b_wren_q <= 1'b0;
        end else begin
            buf_a_wren_q <= rsp_take && (rsp_cnt_q < FETCH_CW'(SA_WIDTH));
            buf_b_wren_q <= rsp_take && (rsp_cnt_q >= FETCH_CW'(SA_WIDTH));
        end
    end

    // beat index within the tile is the buffer address
    always_ff @(posedge clk) begin
        if (rsp_take) begin
            buf_waddr_q <= rsp_cnt_q[BUF_AW-1:0];
            buf_wdata_q <= rd_rdata_i;
        end
    end

    assign buf_a_wr_o = '{wren: buf_a_wren_q, waddr: buf_waddr_q, wdata: buf_wdata_q};
    assign buf_b_wr_o = '{wren: buf_b_wren_q, waddr: buf_waddr_q, wdata: buf_wdata_q};

endmodule

// File: design/mm_accel_top.sv
/*
 * matrix-multiply accelerator top
 * DMA engine, A and B tile buffers and the MAC engine
 */
`timescale 1ns/10ps

module mm_accel_top (
    input  logic                  clk,
    input  logic                  rst_n,

    // job control
    input  mm_pkg::job_cfg_t      cfg_i,
    input  logic                  start_i,
    output logic                  done_o,

    // memory read channel
    output mm_pkg::mem_rd_req_t   rd_req_o,
    input  logic                  rd_ready_i,
    input  logic                  rd_rvalid_i,
    input  mm_pkg::tile_vec_t     rd_rdata_i,

    // memory write channel
    output mm_pkg::mem_wr_t       wr_o,
    input  logic                  wr_ready_i
);
    import mm_pkg::*;

    // DMA to buffers
    buf_wr_t           buf_a_wr;
    buf_wr_t           buf_b_wr;

    // engine to buffers
    logic [BUF_AW-1:0] a_raddr;
    logic [BUF_AW-1:0] b_raddr;
    tile_vec_t         a_col;
    tile_vec_t         b_row;

    // engine handshake and results
    logic              mm_start;
    logic              mm_done;
    acc_tile_t         accum;

    dma_engine u_dma (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_i       (cfg_i),
        .start_i     (start_i),
        .done_o      (done_o),
        .rd_req_o    (rd_req_o),
        .rd_ready_i  (rd_ready_i),
        .rd_rvalid_i (rd_rvalid_i),
        .rd_rdata_i  (rd_rdata_i),
        .buf_a_wr_o  (buf_a_wr),
        .buf_b_wr_o  (buf_b_wr),
        .mm_start_o  (mm_start),
        .mm_done_i   (mm_done),
        .accum_i     (accum),
        .wr_o        (wr_o),
        .wr_ready_i  (wr_ready_i)
    );

    // columns of A
    tile_buffer u_buf_a (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_i    (buf_a_wr),
        .raddr_i (a_raddr),
        .rdata_o (a_col)
    );

    // rows of B
    tile_buffer u_buf_b (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_i    (buf_b_wr),
        .raddr_i (b_raddr),
        .rdata_o (b_row)
    );

    mm_engine u_mm (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (mm_start),
        .a_raddr_o (a_raddr),
        .b_raddr_o (b_raddr),
        .a_col_i   (a_col),
        .b_row_i   (b_row),
        .accum_o   (accum),
        .done_o    (mm_done)
    );

endmodule

// File: design/mm_engine.sv
/*
 * output-stationary multiply-accumulate array
 * walks both tile buffers over k and adds the outer product of
 * column k of A and row k of B into 16 held accumulators
 */
`timescale 1ns/10ps

module mm_engine (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start_i,
    output logic [mm_pkg::BUF_AW-1:0]  a_raddr_o,
    output logic [mm_pkg::BUF_AW-1:0]  b_raddr_o,
    input  mm_pkg::tile_vec_t          a_col_i,
    input  mm_pkg::tile_vec_t          b_row_i,
    output mm_pkg::acc_tile_t          accum_o,
    output logic                       done_o
);
    import mm_pkg::*;

    // address stepping
    logic              busy_q;
    logic [BUF_AW-1:0] k_q;

    // read latency tracking
    logic              rd_vld_q;
    logic              rd_last_q;

    // accumulators, cleared on start, held after done
    acc_tile_t         accum_q;

    // 8x8 signed products, one per array cell
    logic signed [2*ELEM_W-1:0] prod [SA_WIDTH][SA_WIDTH];

    // same address goes to both buffers
    // A holds columns, B holds rows
    assign a_raddr_o = k_q;
    assign b_raddr_o = k_q;

    // k counter
    // cycle after start presents k=0, then 1..3
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            k_q    <= '0;
        end else if (start_i) begin
            busy_q <= 1'b1;
            k_q    <= '0;
        end else if (busy_q) begin
            k_q <= k_q + 1'b1;
            // last address issued
            if (k_q == K_LAST) begin
                busy_q <= 1'b0;
            end
        end
    end

    // valid bit delayed by the buffer read latency
    // done follows the final accumulate
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_vld_q  <= 1'b0;
            rd_last_q <= 1'b0;
            done_o    <= 1'b0;
        end else begin
            rd_vld_q  <= busy_q;
            rd_last_q <= busy_q && (k_q == K_LAST);
            done_o    <= rd_last_q;
        end
    end

    // outer product of the returned column and row
    // C[r][c] += A[r][k] * B[k][c]
    for (genvar r = 0; r < SA_WIDTH; r++) begin : g_row
        for (genvar c = 0; c < SA_WIDTH; c++) begin : g_col
            assign prod[r][c] = a_col_i[r] * b_row_i[c];
        end
    end

    // accumulate, product is sign-extended to ACC_W by the signed add
    always_ff @(posedge clk) begin
        for (int r = 0; r < SA_WIDTH; r++) begin
            for (int c = 0; c < SA_WIDTH; c++) begin
                if (start_i) begin
                    accum_q[r][c] <= '0;
                end else if (rd_vld_q) begin
                    accum_q[r][c] <= accum_q[r][c] + prod[r][c];
                end
            end
        end
    end

    assign accum_o = accum_q;

endmodule

// File: design/mm_pkg.sv
/*
 * matrix-multiply accelerator shared definitions
 * tile sizes, memory word layout and the structs passed between blocks
 */
package mm_pkg;

    // tile geometry
    localparam int SA_WIDTH = 4;
    localparam int ELEM_W   = 8;
    localparam int ACC_W    = 32;

    // memory port
    localparam int MEM_DW     = 32;
    localparam int MEM_AW     = 32;
    localparam int BEAT_BYTES = MEM_DW / 8;

    // buffer addressing, one word per column of A or row of B
    localparam int BUF_AW = 2;
    localparam logic [BUF_AW-1:0] K_LAST = BUF_AW'(SA_WIDTH - 1);

    // beat counts per job
    localparam int READ_BEATS = 2 * SA_WIDTH;
    localparam int C_BEATS    = SA_WIDTH * SA_WIDTH;
    // request/response counters must reach READ_BEATS
    localparam int FETCH_CW   = $clog2(READ_BEATS + 1);
    localparam int C_IDX_W    = $clog2(C_BEATS);

    typedef logic signed [ELEM_W-1:0] elem_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    // one memory beat == one buffer word, element i in bits [8i+7:8i]
    typedef elem_t [SA_WIDTH-1:0] tile_vec_t;

    // result tile, indexed [row][col]
    typedef acc_t [SA_WIDTH-1:0][SA_WIDTH-1:0] acc_tile_t;

    typedef struct packed {
        logic [MEM_AW-1:0] mat_a_addr;
        logic [MEM_AW-1:0] mat_b_addr;
        logic [MEM_AW-1:0] mat_c_addr;
    } job_cfg_t;

    typedef struct packed {
        logic              wren;
        logic [BUF_AW-1:0] waddr;
        tile_vec_t         wdata;
    } buf_wr_t;

    typedef struct packed {
        logic              valid;
        logic [MEM_AW-1:0] addr;
    } mem_rd_req_t;

    typedef struct packed {
        logic              valid;
        logic [MEM_AW-1:0] addr;
        logic [MEM_DW-1:0] data;
    } mem_wr_t;

endpackage

// File: design/tile_buffer.sv
/*
 * tile buffer, SA_WIDTH words deep
 * one write port from the DMA side, one registered read port for the engine
 */
`timescale 1ns/10ps

module tile_buffer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  mm_pkg::buf_wr_t            wr_i,
    input  logic [mm_pkg::BUF_AW-1:0]  raddr_i,
    output mm_pkg::tile_vec_t          rdata_o
);
    import mm_pkg::*;

    // storage array, no reset
    tile_vec_t mem_q [SA_WIDTH];

    // full word writes only
    always_ff @(posedge clk) begin
        if (wr_i.wren) begin
            mem_q[wr_i.waddr] <= wr_i.wdata;
        end
    end

    // registered read, data valid the cycle after raddr_i
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_o <= '0;
        end else begin
            rdata_o <= mem_q[raddr_i];
        end
    end

endmodule

// File: verilog.f
design/mm_pkg.sv
design/tile_buffer.sv
design/mm_engine.sv
design/dma_engine.sv
design/mm_accel_top.sv
bench/mm_accel_props.sv
bench/mm_accel_tb.sv
